//--- tb/mul_unit_input.txt
# columns: tag op a b expected, all hex; op 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
# tags 80 and above form one block that is issued back to back
01 0 00000003 00000007 00000015
02 0 00000000 12345678 00000000
03 0 ffffffff ffffffff 00000001
04 0 80000000 80000000 00000000
05 0 0000ffff 0000ffff fffe0001
06 0 ffffffff 00000002 fffffffe
07 0 12345678 00000010 23456780
10 1 ffffffff ffffffff 00000000
11 1 80000000 80000000 40000000
12 1 80000000 7fffffff c0000000
13 1 7fffffff 7fffffff 3fffffff
14 1 ffffffff 00000002 ffffffff
15 1 00010000 00010000 00000001
16 1 fffffffe 00000003 ffffffff
20 2 ffffffff ffffffff ffffffff
21 2 80000000 ffffffff 80000000
22 2 00000002 ffffffff 00000001
23 2 fffffffe 00000003 ffffffff
30 3 ffffffff ffffffff fffffffe
31 3 80000000 80000000 40000000
32 3 ffffffff 00000002 00000001
33 3 12345678 00010000 00001234
81 0 00000006 00000007 0000002a
82 1 ffffffff 00000001 ffffffff
83 2 ffffffff 00000001 ffffffff
84 3 ffffffff 00000001 00000000
85 0 deadbeef 00000001 deadbeef
86 1 00000000 80000000 00000000
87 3 00000100 01000000 00000001
88 0 0000ffff 00010001 ffffffff

//--- flist.f
+incdir+source
source/mul_pkg.sv
source/booth_partial_product.sv
source/partial_product_array.sv
source/csa_reduction_tree.sv
source/product_finalize.sv
source/mul_unit.sv
tb/mul_unit_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := mul_unit_tb
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed
FAIL_MSG  := Simulation failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

sim: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb/mul_unit_tb.sv
// vector file path is relative to the project root; latency of exactly 3 cycles is assumed
`include "mul_config.svh"

module mul_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mul_pkg::*;

    localparam int          LATENCY    = 3;
    localparam int          RST_CYCLES = 3;
    localparam int unsigned SEED       = 32'he86f;
    localparam string       VEC_FILE   = "tb/mul_unit_input.txt";

    // one line of the vector file
    typedef struct packed {
        logic [7:0]             tag;
        mul_op_t                op;
        logic [`MUL_XLEN-1:0]   a;
        logic [`MUL_XLEN-1:0]   b;
        logic [`MUL_XLEN-1:0]   exp_val;
    } vector_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   in_valid;
    mul_req_t               req;
    logic                   out_valid;
    logic [`MUL_XLEN-1:0]   result;

    vector_t    vectors [$];
    vector_t    pending [$];
    int         issue_cycle [$];
    int         cycle_count  = 0;
    int         cycle_limit  = 0;
    int         checks_done  = 0;
    int         value_errors = 0;
    int         other_errors = 0;

    mul_unit uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .result    (result)
    );

    always #5 clk = ~clk;

    // cycle counter and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic load_vectors(output bit ok);
        int                     fd;
        int                     code;
        string                  line;
        logic [7:0]             tag;
        logic [1:0]             op_bits;
        logic [`MUL_XLEN-1:0]   a;
        logic [`MUL_XLEN-1:0]   b;
        logic [`MUL_XLEN-1:0]   exp_val;
        vector_t                vec;
        ok = 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VEC_FILE);
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                // skip comments and blank lines
                if (code != 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%h %h %h %h %h", tag, op_bits, a, b, exp_val);
                    if (code == 5) begin
                        vec.tag     = tag;
                        vec.op      = mul_op_t'(op_bits);
                        vec.a       = a;
                        vec.b       = b;
                        vec.exp_val = exp_val;
                        vectors.push_back(vec);
                    end else begin
                        $display("could not parse vector line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("the vector file holds no vectors");
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic apply_reset();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic issue_vectors();
        int gap;
        foreach (vectors[i]) begin
            @(posedge clk);
            in_valid <= 1'b1;
            req.op   <= vectors[i].op;
            req.a    <= vectors[i].a;
            req.b    <= vectors[i].b;
            pending.push_back(vectors[i]);
            // tags with bit 7 set form the back-to-back block
            gap = vectors[i].tag[7] ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drain_pipeline();
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        // quiet cycles to catch stray results
        repeat (LATENCY + 2) @(posedge clk);
    endtask

    task automatic check_result();
        vector_t    vec;
        int         issued;
        if (pending.size() == 0 || issue_cycle.size() == 0) begin
            $display("a result (%h) arrived at cycle %0d with no request outstanding",
                     result, cycle_count);
            other_errors++;
        end else begin
            vec    = pending.pop_front();
            issued = issue_cycle.pop_front();
            checks_done++;
            assert (result === vec.exp_val) else begin
                $display("error test %02h op %0d: expected %h, actual %h",
                         vec.tag, vec.op, vec.exp_val, result);
                value_errors++;
            end
            assert (cycle_count - issued == LATENCY) else begin
                $display("test %02h came back %0d cycles after issue instead of %0d",
                         vec.tag, cycle_count - issued, LATENCY);
                other_errors++;
            end
        end
    endtask

    // monitor at the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            // request presented to the DUT in this cycle
            if (in_valid) begin
                issue_cycle.push_back(cycle_count);
            end
            if (out_valid === 1'b1) begin
                check_result();
            end else if (out_valid !== 1'b0) begin
                $display("out_valid is unknown at cycle %0d", cycle_count);
                other_errors++;
            end
        end
    end

    initial begin
        bit loaded;
        rst      = 1'b1;
        in_valid = 1'b0;
        req      = '0;
        void'($urandom(SEED));
        load_vectors(loaded);
        if (!loaded) begin
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = 4 * (vectors.size() + RST_CYCLES + LATENCY) + 20;
            apply_reset();
            issue_vectors();
            drain_pipeline();
            $display("checks: %0d, value errors: %0d, other errors: %0d",
                     checks_done, value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

//--- source/mul_unit.sv
// three-cycle pipelined multiplier, no back-pressure, results must be taken when out_valid is high
`include "mul_config.svh"

module mul_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  mul_pkg::mul_req_t       req,
    output logic                    out_valid,
    output logic [`MUL_XLEN-1:0]    result
);

    import mul_pkg::*;

    // stage 1 to stage 2
    logic                       s1_valid;
    mul_op_t                    s1_op;
    pp_rows_t                   s1_rows;

    // stage 2 to stage 3
    logic                       s2_valid;
    mul_op_t                    s2_op;
    logic [`MUL_PWIDTH-1:0]     s2_sum;
    logic [`MUL_PWIDTH-1:0]     s2_carry;

    partial_product_array u_ppa (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .req      (req),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_rows  (s1_rows)
    );

    csa_reduction_tree u_csa (
        .clk      (clk),
        .rst      (rst),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_rows  (s1_rows),
        .s2_valid (s2_valid),
        .s2_op    (s2_op),
        .s2_sum   (s2_sum),
        .s2_carry (s2_carry)
    );

    product_finalize u_fin (
        .clk       (clk),
        .rst       (rst),
        .s2_valid  (s2_valid),
        .s2_op     (s2_op),
        .s2_sum    (s2_sum),
        .s2_carry  (s2_carry),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- source/product_finalize.sv
// stage 3 of the multiplier; result is only meaningful while out_valid is high
`include "mul_config.svh"

module product_finalize (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s2_valid,
    input  mul_pkg::mul_op_t        s2_op,
    input  logic [`MUL_PWIDTH-1:0]  s2_sum,
    input  logic [`MUL_PWIDTH-1:0]  s2_carry,
    output logic                    out_valid,
    output logic [`MUL_XLEN-1:0]    result
);

    import mul_pkg::*;

    product_t               prod;
    logic [`MUL_XLEN-1:0]   word_sel;

    // carry-propagate add of the redundant pair
    always_comb begin
        prod.word = s2_sum + s2_carry;
    end

    // mul wants the low word, every mulh flavour the high word
    assign word_sel = (s2_op == OP_MUL) ? prod.half.lo : prod.half.hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= word_sel;
    end

    // an X strobe here means a valid bit escaped reset somewhere upstream
    a_out_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(out_valid)
    ) else $error("out_valid is unknown");

endmodule

//--- source/csa_reduction_tree.sv
// stage 2 of the multiplier; all arithmetic is modulo 2^PWIDTH, sum and carry are not reset
`include "mul_config.svh"

module csa_reduction_tree (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    s1_valid,
    input  mul_pkg::mul_op_t        s1_op,
    input  mul_pkg::pp_rows_t       s1_rows,
    output logic                    s2_valid,
    output mul_pkg::mul_op_t        s2_op,
    output logic [`MUL_PWIDTH-1:0]  s2_sum,
    output logic [`MUL_PWIDTH-1:0]  s2_carry
);

    import mul_pkg::*;

    // rows left after one level of 3:2 compressors
    function automatic int next_count(input int n);
        return (n / 3) * 2 + (n % 3);
    endfunction

    // rows entering a given level
    function automatic int count_at(input int lvl);
        int n;
        n = `MUL_ROWS;
        for (int l = 0; l < lvl; l++) begin
            n = next_count(n);
        end
        return n;
    endfunction

    function automatic int num_levels();
        int n;
        int lvls;
        n    = `MUL_ROWS;
        lvls = 0;
        while (n > 2) begin
            n = next_count(n);
            lvls++;
        end
        return lvls;
    endfunction

    // plain sum of all incoming rows
    function automatic logic [`MUL_PWIDTH-1:0] row_total(input pp_rows_t rows);
        logic [`MUL_PWIDTH-1:0] acc;
        acc = '0;
        for (int i = 0; i < `MUL_ROWS; i++) begin
            acc = acc + rows[i];
        end
        return acc;
    endfunction

    // 17 rows take six levels
    localparam int LEVELS = num_levels();

    pp_rows_t level_rows [LEVELS+1];

    assign level_rows[0] = s1_rows;

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int N_IN  = count_at(l);
        localparam int N_GRP = N_IN / 3;
        localparam int N_OUT = next_count(N_IN);

        for (genvar r = 0; r < `MUL_ROWS; r++) begin : g_row
            localparam int B = 3 * (r / 2);

            if (r < 2 * N_GRP && r % 2 == 0) begin : g_sum
                assign level_rows[l+1][r] = level_rows[l][B] ^ level_rows[l][B+1]
                                          ^ level_rows[l][B+2];
            end else if (r < 2 * N_GRP) begin : g_carry
                // majority moves up one bit and the top bit falls off
                assign level_rows[l+1][r] = ((level_rows[l][B] & level_rows[l][B+1])
                                           | (level_rows[l][B] & level_rows[l][B+2])
                                           | (level_rows[l][B+1] & level_rows[l][B+2])) << 1;
            end else if (r < N_OUT) begin : g_pass
                // leftover rows skip this level
                assign level_rows[l+1][r] = level_rows[l][r + N_GRP];
            end else begin : g_idle
                assign level_rows[l+1][r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_op    <= s1_op;
        s2_sum   <= level_rows[LEVELS][0];
        s2_carry <= level_rows[LEVELS][1];
    end

    // compression must keep the sum of all rows
    a_sum_kept: assert property (
        @(posedge clk) disable iff (rst)
        s1_valid |-> (level_rows[LEVELS][0] + level_rows[LEVELS][1] == row_total(s1_rows))
    ) else $error("carry-save pair does not add up to the sum of the rows");

endmodule

//--- source/partial_product_array.sv
// stage 1 of the multiplier; no stall, one request per cycle, row data is not reset
`include "mul_config.svh"

module partial_product_array (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  mul_pkg::mul_req_t   req,
    output logic                s1_valid,
    output mul_pkg::mul_op_t    s1_op,
    output mul_pkg::pp_rows_t   s1_rows
);

    import mul_pkg::*;

    localparam int XL = `MUL_XLEN;
    localparam int EW = `MUL_XLEN + 2;

    logic           a_signed;
    logic           b_signed;
    logic [EW-1:0]  a_ext;
    logic [EW-1:0]  b_ext;
    logic [EW:0]    b_win;
    pp_rows_t       rows;

    // signedness per operation, mulhu and mul treat both as unsigned
    always_comb begin
        a_signed = (req.op == OP_MULH) || (req.op == OP_MULHSU);
        b_signed = (req.op == OP_MULH);
        a_ext    = {{2{a_signed & req.a[XL-1]}}, req.a};
        b_ext    = {{2{b_signed & req.b[XL-1]}}, req.b};
    end

    // implicit zero below bit 0 for the first window
    assign b_win = {b_ext, 1'b0};

    for (genvar i = 0; i < `MUL_ROWS; i++) begin : g_row
        logic [`MUL_PWIDTH-1:0] raw;

        booth_partial_product u_pp (
            .mcand  (a_ext),
            .window (b_win[2*i+2 -: 3]),
            .row    (raw)
        );

        // row i weighs 4^i
        assign rows[i] = raw << (2 * i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op   <= req.op;
        s1_rows <= rows;
    end

    // an unknown opcode would poison the operand extension and every row
    a_op_known: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> !$isunknown(req.op)
    ) else $error("request accepted with unknown op");

endmodule

//--- source/booth_partial_product.sv
// combinational only; mcand must already be sign or zero extended to XLEN+2 bits
`include "mul_config.svh"

module booth_partial_product (
    input  logic [`MUL_XLEN+1:0]    mcand,
    input  logic [2:0]              window,
    output logic [`MUL_PWIDTH-1:0]  row
);

    localparam int EW = `MUL_XLEN + 2;
    localparam int PW = `MUL_PWIDTH;

    logic [PW-1:0] m_pos;
    logic [PW-1:0] m_neg;

    // multiplicand at full row width
    assign m_pos = {{(PW - EW){mcand[EW-1]}}, mcand};

    // two's complement negative
    assign m_neg = ~m_pos + 1'b1;

    always_comb begin
        case (window)
            // +M
            3'b001,
            3'b010: row = m_pos;
            // +2M
            3'b011: row = m_pos << 1;
            // -2M
            3'b100: row = m_neg << 1;
            // -M
            3'b101,
            3'b110: row = m_neg;
            // 000 and 111 contribute nothing
            default: row = '0;
        endcase
    end

endmodule

//--- source/mul_pkg.sv
// types shared by the multiply pipeline; widths come from the included config macros
`include "mul_config.svh"

package mul_pkg;

    // RISC-V M-extension multiply flavours
    typedef enum logic [1:0] {
        OP_MUL    = 2'd0,
        OP_MULH   = 2'd1,
        OP_MULHSU = 2'd2,
        OP_MULHU  = 2'd3
    } mul_op_t;

    // one request as issued by the core
    typedef struct packed {
        mul_op_t                op;
        logic [`MUL_XLEN-1:0]   a;
        logic [`MUL_XLEN-1:0]   b;
    } mul_req_t;

    // all Booth rows, already shifted into place
    typedef logic [`MUL_ROWS-1:0][`MUL_PWIDTH-1:0] pp_rows_t;

    typedef struct packed {
        logic [`MUL_XLEN-1:0]   hi;
        logic [`MUL_XLEN-1:0]   lo;
    } product_halves_t;

    // full product, read either as one word or as two halves
    typedef union packed {
        logic [`MUL_PWIDTH-1:0] word;
        product_halves_t        half;
    } product_t;

endpackage

//--- source/mul_config.svh
// MUL_XLEN must be even and at least 4; row and width macros are derived from it
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// operand width of the core
`define MUL_XLEN 32

// radix-4 Booth rows over the operand widened by two bits
`define MUL_ROWS (`MUL_XLEN / 2 + 1)

// partial-product row width, wide enough for the full product
`define MUL_PWIDTH (2 * `MUL_XLEN)

`endif
